//--- test/gbe_cpu_tests.txt
# op addr sel data expect; W/R bus write/read, X/Y write/read that must end in err
# F rx fill entry addr with {data,expect}; D tx done; K soft reset ack; Z rx size; C output addr
R 0000 f 00000000 0000ffff
R 0004 f 00000000 ffffffff
R 0018 f 00000000 00000000
R 0020 f 00000000 0000ffff
R 0024 f 00000000 c3e1005a
R 0028 f 00000000 0a040007
R 0034 f 00000000 00000000
C 0007 0 00000000 00000000
W 0004 5 11223344 00000000
R 0004 f 00000000 ff22ff44
W 0000 2 0000ab00 00000000
C 0000 0 00000000 0000abff
W 0010 c c0a80000 00000000
C 0002 0 00000000 c0a8ffff
W 0020 5 00011234 00000000
R 0020 f 00000000 0001ff34
C 0003 0 00000000 0000ff34
W 0030 8 e0000000 00000000
C 0004 0 00000000 e0000000
W 0028 a 05000300 00000000
R 0028 f 00000000 05040307
C 0006 0 00000000 0000541f
W 1028 f 01234567 00000000
W 102c f 89abcdef 00000000
W 1028 6 aabbccdd 00000000
R 1028 f 00000000 01bbcc67
R 102c f 00000000 89abcdef
W 3010 1 deadbeef 00000000
W 3014 3 00112233 00000000
R 3010 f 00000000 0000beef
R 3014 f 00000000 00112233
F 0003 0 cafef00d 12345678
R 2018 f 00000000 cafef00d
R 201c f 00000000 12345678
X 2018 f 55555555 00000000
Y 0800 f 00000000 00000000
R 2018 f 00000000 cafef00d
Z 0000 0 00000027 00000000
W 0018 4 00400000 00000000
R 0018 f 00000000 00400027
W 0018 1 00000000 00000000
R 0018 f 00000000 00400000
C 0007 0 00000000 00000006
D 0000 0 00000000 00000000
R 0018 f 00000000 00000027
C 0007 0 00000000 00000000
W 0020 8 01000000 00000000
C 0007 0 00000000 00000001
K 0000 0 00000000 00000000
C 0007 0 00000000 00000000

//--- gbe_cpu_top.f
+incdir+hdl
hdl/gbe_cpu_pkg.sv
hdl/gbe_wb_decode.sv
hdl/gbe_cfg_regs.sv
hdl/gbe_buf_port.sv
hdl/gbe_cpu_ram.sv
hdl/gbe_cpu_top.sv
test/gbe_cpu_sva.sv
test/gbe_cpu_checker.sv
test/gbe_cpu_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f gbe_cpu_top.f --top-module gbe_cpu_tb
	./obj_dir/Vgbe_cpu_tb +verilator+error+limit+100 | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/gbe_cpu_tb.sv
`timescale 1ns/1ps

module gbe_cpu_tb import gbe_cpu_pkg::*; ();

  logic        wb_clk_i = 1'b0;
  logic        wb_rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  wb_word_t    wb_adr_i;
  wb_sel_t     wb_sel_i;
  wb_word_t    wb_dat_i;
  wb_word_t    wb_dat_o;
  logic        wb_ack_o;
  logic        wb_err_o;
  logic        rx_fill_we_i;
  buf_addr_t   rx_fill_addr_i;
  buf_word_t   rx_fill_data_i;
  buf_size_t   cpu_rx_size_i;
  logic        cpu_tx_done_i;
  logic        soft_reset_ack_i;
  logic [7:0]  xaui_status_i;
  logic [15:0] mgt_status_i;
  mac_addr_t   local_mac_o;
  ip_addr_t    local_ip_o;
  udp_port_t   local_port_o;
  logic [7:0]  local_gateway_o;
  logic        local_enable_o;
  ip_addr_t    local_mc_ip_o;
  ip_addr_t    local_mc_mask_o;
  logic [2:0]  mgt_rxeqmix_o;
  logic [3:0]  mgt_txpreemph_o;
  logic [4:0]  mgt_txpostemph_o;
  logic [3:0]  mgt_txdiffctrl_o;
  buf_size_t   cpu_tx_size_o;
  logic        cpu_tx_ready_o;
  logic        cpu_rx_ack_o;
  logic        soft_reset_o;

  // expected response, handed to the checker
  logic        exp_read;
  logic        exp_err;
  wb_word_t    exp_data;
  logic        out_chk;
  logic [3:0]  out_idx;
  wb_word_t    out_exp;

  int data_errors;
  int resp_errors;
  int out_errors;
  int file_errors = 0;
  int cycles = 0;
  int limit = 0;

  logic [7:0] op_q[$];
  wb_word_t   adr_q[$];
  wb_sel_t    sel_q[$];
  wb_word_t   dat_q[$];
  wb_word_t   exp_q[$];

  always #2 wb_clk_i = ~wb_clk_i;

  gbe_cpu_top gbe_cpu_top_i (.*);

  gbe_cpu_checker gbe_cpu_checker_i (
    .wb_clk_i        (wb_clk_i),
    .wb_ack_i        (wb_ack_o),
    .wb_err_i        (wb_err_o),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_o),
    .exp_read_i      (exp_read),
    .exp_err_i       (exp_err),
    .exp_data_i      (exp_data),
    .out_chk_i       (out_chk),
    .out_idx_i       (out_idx),
    .out_exp_i       (out_exp),
    .local_mac_i     (local_mac_o),
    .local_ip_i      (local_ip_o),
    .local_port_i    (local_port_o),
    .local_gateway_i (local_gateway_o),
    .local_enable_i  (local_enable_o),
    .local_mc_ip_i   (local_mc_ip_o),
    .local_mc_mask_i (local_mc_mask_o),
    .tx_size_i       (cpu_tx_size_o),
    .phy_cfg_i       ({mgt_txdiffctrl_o, mgt_txpreemph_o, mgt_txpostemph_o, mgt_rxeqmix_o}),
    .flags_i         ({cpu_tx_ready_o, cpu_rx_ack_o, soft_reset_o}),
    .data_errors_o   (data_errors),
    .resp_errors_o   (resp_errors),
    .out_errors_o    (out_errors)
  );

  task automatic bus_cycle(input logic we, input logic err, input wb_word_t adr,
                           input wb_sel_t sel, input wb_word_t dat, input wb_word_t exp_w);
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_sel_i <= sel;
    wb_dat_i <= dat;
    exp_read <= !we;
    exp_err  <= err;
    exp_data <= exp_w;
    do
      @(posedge wb_clk_i);
    while (!(wb_ack_o || wb_err_o));
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic apply_op(input int i);
    case (op_q[i])
      "W": bus_cycle(1'b1, 1'b0, adr_q[i], sel_q[i], dat_q[i], exp_q[i]);
      "R": bus_cycle(1'b0, 1'b0, adr_q[i], sel_q[i], dat_q[i], exp_q[i]);
      "X": bus_cycle(1'b1, 1'b1, adr_q[i], sel_q[i], dat_q[i], exp_q[i]);
      "Y": bus_cycle(1'b0, 1'b1, adr_q[i], sel_q[i], dat_q[i], exp_q[i]);
      "F": begin
        @(posedge wb_clk_i);
        rx_fill_we_i   <= 1'b1;
        rx_fill_addr_i <= adr_q[i][7:0];
        rx_fill_data_i <= {dat_q[i], exp_q[i]};
        @(posedge wb_clk_i);
        rx_fill_we_i   <= 1'b0;
      end
      "D": begin
        @(posedge wb_clk_i);
        cpu_tx_done_i <= 1'b1;
        @(posedge wb_clk_i);
        cpu_tx_done_i <= 1'b0;
      end
      "K": begin
        @(posedge wb_clk_i);
        soft_reset_ack_i <= 1'b1;
        @(posedge wb_clk_i);
        soft_reset_ack_i <= 1'b0;
      end
      "Z": begin
        @(posedge wb_clk_i);
        cpu_rx_size_i <= dat_q[i][7:0];
      end
      "C": begin
        @(posedge wb_clk_i);
        out_chk <= 1'b1;
        out_idx <= adr_q[i][3:0];
        out_exp <= exp_q[i];
        @(posedge wb_clk_i);
        out_chk <= 1'b0;
      end
      default: begin
        file_errors++;
        $display("unknown opcode %s in test operation %0d", op_q[i], i + 1);
      end
    endcase
  endtask

  // run limit
  always @(posedge wb_clk_i) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: tests did not finish within %0d cycles", limit);
      $display("errors: %0d data, %0d response, %0d output, %0d assertion, %0d file",
               data_errors, resp_errors, out_errors,
               gbe_cpu_top_i.gbe_cpu_sva_i.assert_fails, file_errors);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    int fd;
    int n;
    int total;
    string line;
    logic [7:0] op;
    wb_word_t adr;
    wb_sel_t sel;
    wb_word_t dat;
    wb_word_t exp_w;
    wb_rst_i         <= 1'b1;
    wb_cyc_i         <= 1'b0;
    wb_stb_i         <= 1'b0;
    wb_we_i          <= 1'b0;
    wb_adr_i         <= '0;
    wb_sel_i         <= '0;
    wb_dat_i         <= '0;
    rx_fill_we_i     <= 1'b0;
    rx_fill_addr_i   <= '0;
    rx_fill_data_i   <= '0;
    cpu_rx_size_i    <= '0;
    cpu_tx_done_i    <= 1'b0;
    soft_reset_ack_i <= 1'b0;
    xaui_status_i    <= 8'h5a;
    mgt_status_i     <= 16'hc3e1;
    exp_read         <= 1'b0;
    exp_err          <= 1'b0;
    exp_data         <= '0;
    out_chk          <= 1'b0;
    out_idx          <= '0;
    out_exp          <= '0;

    fd = $fopen("test/gbe_cpu_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file test/gbe_cpu_tests.txt");
      file_errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%s %h %h %h %h", op, adr, sel, dat, exp_w);
          if (n == 5) begin
            op_q.push_back(op);
            adr_q.push_back(adr);
            sel_q.push_back(sel);
            dat_q.push_back(dat);
            exp_q.push_back(exp_w);
          end else begin
            file_errors++;
            $display("could not parse test line: %s", line);
          end
        end
      end
      $fclose(fd);
      if (op_q.size() == 0) begin
        file_errors++;
        $display("no test operations found in test/gbe_cpu_tests.txt");
      end
    end
    limit = 8 * op_q.size() + 100;

    repeat (2) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    foreach (op_q[i])
      apply_op(i);
    // let the checker see the last response
    repeat (4) @(posedge wb_clk_i);

    total = data_errors + resp_errors + out_errors + file_errors +
            gbe_cpu_top_i.gbe_cpu_sva_i.assert_fails;
    $display("errors: %0d data, %0d response, %0d output, %0d assertion, %0d file",
             data_errors, resp_errors, out_errors,
             gbe_cpu_top_i.gbe_cpu_sva_i.assert_fails, file_errors);
    if (total == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- test/gbe_cpu_checker.sv
`timescale 1ns/1ps

module gbe_cpu_checker import gbe_cpu_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        wb_ack_i,
  input  logic        wb_err_i,
  input  wb_word_t    wb_adr_i,
  input  wb_word_t    wb_dat_i,
  input  logic        exp_read_i,
  input  logic        exp_err_i,
  input  wb_word_t    exp_data_i,
  input  logic        out_chk_i,
  input  logic [3:0]  out_idx_i,
  input  wb_word_t    out_exp_i,
  input  mac_addr_t   local_mac_i,
  input  ip_addr_t    local_ip_i,
  input  udp_port_t   local_port_i,
  input  logic [7:0]  local_gateway_i,
  input  logic        local_enable_i,
  input  ip_addr_t    local_mc_ip_i,
  input  ip_addr_t    local_mc_mask_i,
  input  buf_size_t   tx_size_i,
  input  logic [15:0] phy_cfg_i,
  input  logic [2:0]  flags_i,
  output int          data_errors_o,
  output int          resp_errors_o,
  output int          out_errors_o
);

  int data_errors = 0;
  int resp_errors = 0;
  int out_errors = 0;

  assign data_errors_o = data_errors;
  assign resp_errors_o = resp_errors;
  assign out_errors_o  = out_errors;

  // config outputs against the fields of the expected register word
  function automatic logic outputs_match(logic [3:0] idx, wb_word_t exp_w);
    case (idx)
      4'd3:    return local_gateway_i === exp_w[7:0];
      4'd6:    return tx_size_i === exp_w[23:16];
      4'd8:    return local_enable_i === exp_w[16];
      4'd13:   return local_mc_mask_i === exp_w;
      default: return 1'b1;
    endcase
  endfunction

  // mid-cycle sampling, away from the edges
  always @(negedge wb_clk_i) begin
    wb_word_t actual;
    if (wb_ack_i || wb_err_i) begin
      if (wb_err_i != exp_err_i) begin
        resp_errors++;
        $display("mismatch at %0t: got %s, expected %s", $time,
                 wb_err_i ? "err" : "ack", exp_err_i ? "err" : "ack");
      end else if (wb_ack_i && exp_read_i && wb_dat_i !== exp_data_i) begin
        data_errors++;
        $display("mismatch at %0t: read data %h, expected %h", $time, wb_dat_i, exp_data_i);
      end else if (wb_ack_i && exp_read_i && wb_adr_i[31:11] == '0 &&
                   !outputs_match(wb_adr_i[5:2], exp_data_i)) begin
        out_errors++;
        $display("mismatch at %0t: outputs disagree with register %0d read %h", $time,
                 wb_adr_i[5:2], exp_data_i);
      end
    end
    // read data bus idles at zero between acks
    if (!wb_ack_i && wb_dat_i !== '0) begin
      data_errors++;
      $display("mismatch at %0t: read data %h while ack is low", $time, wb_dat_i);
    end
    if (out_chk_i) begin
      case (out_idx_i)
        4'd0:    actual = {16'b0, local_mac_i[47:32]};
        4'd1:    actual = local_mac_i[31:0];
        4'd2:    actual = local_ip_i;
        4'd3:    actual = {16'b0, local_port_i};
        4'd4:    actual = local_mc_ip_i;
        4'd6:    actual = {16'b0, phy_cfg_i};
        4'd7:    actual = {29'b0, flags_i};
        default: actual = '0;
      endcase
      if (actual !== out_exp_i) begin
        out_errors++;
        $display("mismatch at %0t: output group %0d is %h, expected %h", $time,
                 out_idx_i, actual, out_exp_i);
      end
    end
  end

endmodule

//--- test/gbe_cpu_sva.sv
`timescale 1ns/1ps

module gbe_cpu_sva (
  input logic wb_clk_i,
  input logic wb_rst_i,
  input logic wb_cyc_i,
  input logic wb_ack_i,
  input logic wb_err_i
);

  int assert_fails = 0;

  ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wb_ack_i && wb_err_i))
    else begin
      assert_fails++;
      $error("ack and err high together");
    end

  ack_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_i |=> !wb_ack_i)
    else begin
      assert_fails++;
      $error("ack longer than one cycle");
    end

  err_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_err_i |=> !wb_err_i)
    else begin
      assert_fails++;
      $error("err longer than one cycle");
    end

  // responses only inside a bus cycle
  resp_in_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_ack_i || wb_err_i) |-> wb_cyc_i)
    else begin
      assert_fails++;
      $error("response without cyc");
    end

endmodule

bind gbe_cpu_top gbe_cpu_sva gbe_cpu_sva_i (
  .wb_clk_i (wb_clk_i),
  .wb_rst_i (wb_rst_i),
  .wb_cyc_i (wb_cyc_i),
  .wb_ack_i (wb_ack_o),
  .wb_err_i (wb_err_o)
);

//--- hdl/gbe_cpu_top.sv
`timescale 1ns/1ps
`include "gbe_cpu_defines.svh"

module gbe_cpu_top import gbe_cpu_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  wb_word_t    wb_adr_i,
  input  wb_sel_t     wb_sel_i,
  input  wb_word_t    wb_dat_i,
  output wb_word_t    wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,
  input  logic        rx_fill_we_i,
  input  buf_addr_t   rx_fill_addr_i,
  input  buf_word_t   rx_fill_data_i,
  input  buf_size_t   cpu_rx_size_i,
  input  logic        cpu_tx_done_i,
  input  logic        soft_reset_ack_i,
  input  logic [7:0]  xaui_status_i,
  input  logic [15:0] mgt_status_i,
  output mac_addr_t   local_mac_o,
  output ip_addr_t    local_ip_o,
  output udp_port_t   local_port_o,
  output logic [7:0]  local_gateway_o,
  output logic        local_enable_o,
  output ip_addr_t    local_mc_ip_o,
  output ip_addr_t    local_mc_mask_o,
  output logic [2:0]  mgt_rxeqmix_o,
  output logic [3:0]  mgt_txpreemph_o,
  output logic [4:0]  mgt_txpostemph_o,
  output logic [3:0]  mgt_txdiffctrl_o,
  output buf_size_t   cpu_tx_size_o,
  output logic        cpu_tx_ready_o,
  output logic        cpu_rx_ack_o,
  output logic        soft_reset_o
);

  wb_region_e region;
  wb_region_e region_q;
  buf_addr_t  word;
  logic       hi_half;
  logic       reg_we;
  logic       reg_sel;
  logic       mem_we;
  logic       accept;
  wb_word_t   reg_rdata;
  wb_word_t   mem_rdata;
  buf_word_t  tx_rd;
  buf_word_t  tx_wr;
  buf_word_t  rx_rd;
  arp_word_t  arp_rd;
  arp_word_t  arp_wr;
  logic       tx_we;
  logic       arp_we;
  logic       mem_region;

  gbe_wb_decode gbe_wb_decode_i (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_ack_o  (wb_ack_o),
    .wb_err_o  (wb_err_o),
    .region_o  (region),
    .word_o    (word),
    .hi_half_o (hi_half),
    .reg_we_o  (reg_we),
    .reg_sel_o (reg_sel),
    .mem_we_o  (mem_we),
    .accept_o  (accept)
  );

  // region of the cycle in flight
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i)
      region_q <= region_none;
    else if (accept)
      region_q <= region;
  end

  assign tx_we  = mem_we && (region_q == region_txbuf);
  assign arp_we = mem_we && (region_q == region_arp);

  gbe_cfg_regs gbe_cfg_regs_i (
    .wb_clk_i         (wb_clk_i),
    .wb_rst_i         (wb_rst_i),
    .reg_we_i         (reg_we),
    .reg_sel_i        (reg_sel),
    .reg_idx_i        (wb_adr_i[5:2]),
    .wb_sel_i         (wb_sel_i),
    .wb_dat_i         (wb_dat_i),
    .xaui_status_i    (xaui_status_i),
    .mgt_status_i     (mgt_status_i),
    .cpu_rx_size_i    (cpu_rx_size_i),
    .cpu_tx_done_i    (cpu_tx_done_i),
    .soft_reset_ack_i (soft_reset_ack_i),
    .reg_rdata_o      (reg_rdata),
    .local_mac_o      (local_mac_o),
    .local_ip_o       (local_ip_o),
    .local_port_o     (local_port_o),
    .local_gateway_o  (local_gateway_o),
    .local_enable_o   (local_enable_o),
    .local_mc_ip_o    (local_mc_ip_o),
    .local_mc_mask_o  (local_mc_mask_o),
    .mgt_rxeqmix_o    (mgt_rxeqmix_o),
    .mgt_txpreemph_o  (mgt_txpreemph_o),
    .mgt_txpostemph_o (mgt_txpostemph_o),
    .mgt_txdiffctrl_o (mgt_txdiffctrl_o),
    .cpu_tx_size_o    (cpu_tx_size_o),
    .cpu_tx_ready_o   (cpu_tx_ready_o),
    .cpu_rx_ack_o     (cpu_rx_ack_o),
    .soft_reset_o     (soft_reset_o)
  );

  gbe_buf_port gbe_buf_port_i (
    .region_i    (region_q),
    .hi_half_i   (hi_half),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_i    (wb_dat_i),
    .tx_rd_i     (tx_rd),
    .rx_rd_i     (rx_rd),
    .arp_rd_i    (arp_rd),
    .tx_wr_o     (tx_wr),
    .arp_wr_o    (arp_wr),
    .mem_rdata_o (mem_rdata)
  );

  gbe_cpu_ram #(
    .WIDTH      ($bits(buf_word_t)),
    .DEPTH_LOG2 (`BUF_DEPTH_LOG2)
  ) tx_ram_i (
    .wb_clk_i    (wb_clk_i),
    .addr_i      (word),
    .we_i        (tx_we),
    .wdata_i     (tx_wr),
    .fill_we_i   (1'b0),
    .fill_addr_i ('0),
    .fill_data_i ('0),
    .rdata_o     (tx_rd)
  );

  // cpu side is read only
  gbe_cpu_ram #(
    .WIDTH      ($bits(buf_word_t)),
    .DEPTH_LOG2 (`BUF_DEPTH_LOG2)
  ) rx_ram_i (
    .wb_clk_i    (wb_clk_i),
    .addr_i      (word),
    .we_i        (1'b0),
    .wdata_i     ('0),
    .fill_we_i   (rx_fill_we_i),
    .fill_addr_i (rx_fill_addr_i),
    .fill_data_i (rx_fill_data_i),
    .rdata_o     (rx_rd)
  );

  gbe_cpu_ram #(
    .WIDTH      ($bits(arp_word_t)),
    .DEPTH_LOG2 (`BUF_DEPTH_LOG2)
  ) arp_ram_i (
    .wb_clk_i    (wb_clk_i),
    .addr_i      (word),
    .we_i        (arp_we),
    .wdata_i     (arp_wr),
    .fill_we_i   (1'b0),
    .fill_addr_i ('0),
    .fill_data_i ('0),
    .rdata_o     (arp_rd)
  );

  assign mem_region = (region_q == region_txbuf) || (region_q == region_rxbuf) ||
                      (region_q == region_arp);

  // bus data only valid alongside ack
  assign wb_dat_o = !wb_ack_o  ? '0        :
                    mem_region ? mem_rdata :
                                 reg_rdata;

endmodule

//--- hdl/gbe_cpu_ram.sv
`timescale 1ns/1ps

module gbe_cpu_ram #(
  parameter int WIDTH      = 64,
  parameter int DEPTH_LOG2 = 8
) (
  input  logic                  wb_clk_i,
  input  logic [DEPTH_LOG2-1:0] addr_i,
  input  logic                  we_i,
  input  logic [WIDTH-1:0]      wdata_i,
  input  logic                  fill_we_i,
  input  logic [DEPTH_LOG2-1:0] fill_addr_i,
  input  logic [WIDTH-1:0]      fill_data_i,
  output logic [WIDTH-1:0]      rdata_o
);

  logic [WIDTH-1:0] mem [2**DEPTH_LOG2];

  always_ff @(posedge wb_clk_i) begin
    if (we_i)
      mem[addr_i] <= wdata_i;
    // fabric side write
    if (fill_we_i)
      mem[fill_addr_i] <= fill_data_i;
    rdata_o <= mem[addr_i];
  end

endmodule

//--- hdl/gbe_buf_port.sv
`timescale 1ns/1ps

module gbe_buf_port import gbe_cpu_pkg::*; (
  input  wb_region_e region_i,
  input  logic       hi_half_i,
  input  wb_sel_t    wb_sel_i,
  input  wb_word_t   wb_dat_i,
  input  buf_word_t  tx_rd_i,
  input  buf_word_t  rx_rd_i,
  input  arp_word_t  arp_rd_i,
  output buf_word_t  tx_wr_o,
  output arp_word_t  arp_wr_o,
  output wb_word_t   mem_rdata_o
);

  function automatic wb_word_t half_of(buf_word_t entry, logic hi);
    return hi ? entry[63:32] : entry[31:0];
  endfunction

  // tx buffer merge, selected half only, per byte lane
  always_comb begin
    tx_wr_o = tx_rd_i;
    for (int i = 0; i < 4; i++) begin
      if (wb_sel_i[i]) begin
        if (hi_half_i)
          tx_wr_o[32 + 8*i +: 8] = wb_dat_i[8*i +: 8];
        else
          tx_wr_o[8*i +: 8] = wb_dat_i[8*i +: 8];
      end
    end
  end

  // arp entry is a 48 bit MAC, selects ignored
  always_comb begin
    if (hi_half_i)
      arp_wr_o = {wb_dat_i[15:0], arp_rd_i[31:0]};
    else
      arp_wr_o = {arp_rd_i[47:32], wb_dat_i};
  end

  always_comb begin
    case (region_i)
      region_txbuf:
        mem_rdata_o = half_of(tx_rd_i, hi_half_i);
      region_rxbuf:
        mem_rdata_o = half_of(rx_rd_i, hi_half_i);
      region_arp:
        mem_rdata_o = hi_half_i ? {16'b0, arp_rd_i[47:32]} : arp_rd_i[31:0];
      default:
        mem_rdata_o = '0;
    endcase
  end

endmodule

//--- hdl/gbe_cfg_regs.sv
`timescale 1ns/1ps
`include "gbe_cpu_defines.svh"

module gbe_cfg_regs import gbe_cpu_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        reg_we_i,
  input  logic        reg_sel_i,
  input  logic [3:0]  reg_idx_i,
  input  wb_sel_t     wb_sel_i,
  input  wb_word_t    wb_dat_i,
  input  logic [7:0]  xaui_status_i,
  input  logic [15:0] mgt_status_i,
  input  buf_size_t   cpu_rx_size_i,
  input  logic        cpu_tx_done_i,
  input  logic        soft_reset_ack_i,
  output wb_word_t    reg_rdata_o,
  output mac_addr_t   local_mac_o,
  output ip_addr_t    local_ip_o,
  output udp_port_t   local_port_o,
  output logic [7:0]  local_gateway_o,
  output logic        local_enable_o,
  output ip_addr_t    local_mc_ip_o,
  output ip_addr_t    local_mc_mask_o,
  output logic [2:0]  mgt_rxeqmix_o,
  output logic [3:0]  mgt_txpreemph_o,
  output logic [4:0]  mgt_txpostemph_o,
  output logic [3:0]  mgt_txdiffctrl_o,
  output buf_size_t   cpu_tx_size_o,
  output logic        cpu_tx_ready_o,
  output logic        cpu_rx_ack_o,
  output logic        soft_reset_o
);

  logic [3:0] rd_idx_q;

  function automatic wb_word_t lane_merge(wb_word_t old_w, wb_word_t new_w, wb_sel_t sel);
    wb_word_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (sel[i])
        res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      rd_idx_q         <= '0;
      local_mac_o      <= `DEF_MAC;
      local_ip_o       <= `DEF_IP;
      local_port_o     <= `DEF_PORT;
      local_gateway_o  <= `DEF_GATEWAY;
      local_enable_o   <= `DEF_ENABLE;
      local_mc_ip_o    <= `DEF_MC_IP;
      local_mc_mask_o  <= `DEF_MC_MASK;
      mgt_rxeqmix_o    <= `DEF_RXEQMIX;
      mgt_txpreemph_o  <= `DEF_PREEMPH;
      mgt_txpostemph_o <= `DEF_POSTEMPH;
      mgt_txdiffctrl_o <= `DEF_DIFFCTRL;
      cpu_tx_size_o    <= '0;
      cpu_tx_ready_o   <= 1'b0;
      cpu_rx_ack_o     <= 1'b0;
      soft_reset_o     <= 1'b0;
    end else begin
      // packet sent by the fabric
      if (cpu_tx_done_i) begin
        cpu_tx_size_o  <= '0;
        cpu_tx_ready_o <= 1'b0;
      end
      // rx double buffer swapped once tx size is back to zero
      if (cpu_tx_size_o == '0)
        cpu_rx_ack_o <= 1'b0;
      if (soft_reset_ack_i)
        soft_reset_o <= 1'b0;
      if (reg_sel_i)
        rd_idx_q <= reg_idx_i;
      if (reg_we_i) begin
        case (reg_idx_i)
          `REG_MAC_HI: begin
            if (wb_sel_i[0])
              local_mac_o[39:32] <= wb_dat_i[7:0];
            if (wb_sel_i[1])
              local_mac_o[47:40] <= wb_dat_i[15:8];
          end
          `REG_MAC_LO:
            local_mac_o[31:0] <= lane_merge(local_mac_o[31:0], wb_dat_i, wb_sel_i);
          `REG_GATEWAY: begin
            if (wb_sel_i[0])
              local_gateway_o <= wb_dat_i[7:0];
          end
          `REG_IPADDR:
            local_ip_o <= lane_merge(local_ip_o, wb_dat_i, wb_sel_i);
          `REG_BUF_SIZES: begin
            if (wb_sel_i[0] && wb_dat_i[7:0] == 8'd0)
              cpu_rx_ack_o <= 1'b1;
            if (wb_sel_i[2]) begin
              cpu_tx_size_o  <= wb_dat_i[23:16];
              cpu_tx_ready_o <= 1'b1;
            end
          end
          `REG_PORT_CTRL: begin
            if (wb_sel_i[0])
              local_port_o[7:0] <= wb_dat_i[7:0];
            if (wb_sel_i[1])
              local_port_o[15:8] <= wb_dat_i[15:8];
            if (wb_sel_i[2])
              local_enable_o <= wb_dat_i[16];
            if (wb_sel_i[3] && wb_dat_i[24])
              soft_reset_o <= 1'b1;
          end
          `REG_PHY_CONFIG: begin
            if (wb_sel_i[0])
              mgt_rxeqmix_o <= wb_dat_i[2:0];
            if (wb_sel_i[1])
              mgt_txpostemph_o <= wb_dat_i[12:8];
            if (wb_sel_i[2])
              mgt_txpreemph_o <= wb_dat_i[19:16];
            if (wb_sel_i[3])
              mgt_txdiffctrl_o <= wb_dat_i[27:24];
          end
          `REG_MC_IP:
            local_mc_ip_o <= lane_merge(local_mc_ip_o, wb_dat_i, wb_sel_i);
          `REG_MC_MASK:
            local_mc_mask_o <= lane_merge(local_mc_mask_o, wb_dat_i, wb_sel_i);
          default: begin
          end
        endcase
      end
    end
  end

  always_comb begin
    case (rd_idx_q)
      `REG_MAC_HI:      reg_rdata_o = {16'b0, local_mac_o[47:32]};
      `REG_MAC_LO:      reg_rdata_o = local_mac_o[31:0];
      `REG_GATEWAY:     reg_rdata_o = {24'b0, local_gateway_o};
      `REG_IPADDR:      reg_rdata_o = local_ip_o;
      `REG_BUF_SIZES:   reg_rdata_o = {8'b0, cpu_tx_size_o, 8'b0,
                                       cpu_rx_ack_o ? 8'b0 : cpu_rx_size_i};
      `REG_PORT_CTRL:   reg_rdata_o = {7'b0, soft_reset_o, 7'b0, local_enable_o, local_port_o};
      `REG_XAUI_STATUS: reg_rdata_o = {mgt_status_i, 8'b0, xaui_status_i};
      `REG_PHY_CONFIG:  reg_rdata_o = {4'b0, mgt_txdiffctrl_o, 4'b0, mgt_txpreemph_o,
                                       3'b0, mgt_txpostemph_o, 5'b0, mgt_rxeqmix_o};
      `REG_MC_IP:       reg_rdata_o = local_mc_ip_o;
      `REG_MC_MASK:     reg_rdata_o = local_mc_mask_o;
      default:          reg_rdata_o = '0;
    endcase
  end

endmodule

//--- hdl/gbe_wb_decode.sv
`timescale 1ns/1ps
`include "gbe_cpu_defines.svh"

module gbe_wb_decode import gbe_cpu_pkg::*; (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  input  logic       wb_cyc_i,
  input  logic       wb_stb_i,
  input  logic       wb_we_i,
  input  wb_word_t   wb_adr_i,
  output logic       wb_ack_o,
  output logic       wb_err_o,
  output wb_region_e region_o,
  output buf_addr_t  word_o,
  output logic       hi_half_o,
  output logic       reg_we_o,
  output logic       reg_sel_o,
  output logic       mem_we_o,
  output logic       accept_o
);

  logic wait_q;
  logic illegal;
  logic mem_wr;

  function automatic logic in_window(wb_word_t adr, wb_word_t base, wb_word_t high);
    return (adr - base) <= (high - base);
  endfunction

  always_comb begin
    region_o = region_none;
    if (in_window(wb_adr_i, `REGS_BASE, `REGS_HIGH))
      region_o = region_regs;
    else if (in_window(wb_adr_i, `TXBUF_BASE, `TXBUF_HIGH))
      region_o = region_txbuf;
    else if (in_window(wb_adr_i, `RXBUF_BASE, `RXBUF_HIGH))
      region_o = region_rxbuf;
    else if (in_window(wb_adr_i, `ARP_BASE, `ARP_HIGH))
      region_o = region_arp;
  end

  // upper 32 bits live at the lower word address
  assign word_o    = wb_adr_i[10:3];
  assign hi_half_o = ~wb_adr_i[2];

  assign accept_o  = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o && !wait_q;
  assign illegal   = (region_o == region_none) || (region_o == region_rxbuf && wb_we_i);
  assign mem_wr    = wb_we_i && (region_o == region_txbuf || region_o == region_arp);

  assign reg_sel_o = accept_o && (region_o == region_regs);
  assign reg_we_o  = reg_sel_o && wb_we_i;

  // old entry is back from the RAM by now
  assign mem_we_o  = wait_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      wait_q   <= 1'b0;
    end else begin
      wb_ack_o <= wait_q || (accept_o && !illegal && !mem_wr);
      wb_err_o <= accept_o && illegal;
      wait_q   <= accept_o && mem_wr;
    end
  end

endmodule

//--- hdl/gbe_cpu_pkg.sv
package gbe_cpu_pkg;

  // wishbone side
  typedef logic [31:0] wb_word_t;
  typedef logic [3:0]  wb_sel_t;

  // memory entries, 256 deep
  typedef logic [7:0]  buf_addr_t;
  typedef logic [63:0] buf_word_t;
  typedef logic [47:0] arp_word_t;

  // network fields
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [7:0]  buf_size_t;

  typedef enum logic [2:0] {
    region_none,
    region_regs,
    region_txbuf,
    region_rxbuf,
    region_arp
  } wb_region_e;

endpackage

//--- hdl/gbe_cpu_defines.svh
`ifndef GBE_CPU_DEFINES_SVH
`define GBE_CPU_DEFINES_SVH

// address windows
`define REGS_BASE       32'h0000_0000
`define REGS_HIGH       32'h0000_07ff
`define TXBUF_BASE      32'h0000_1000
`define TXBUF_HIGH      32'h0000_17ff
`define RXBUF_BASE      32'h0000_2000
`define RXBUF_HIGH      32'h0000_27ff
`define ARP_BASE        32'h0000_3000
`define ARP_HIGH        32'h0000_37ff
`define BUF_DEPTH_LOG2  8

// register word index, address bits 5:2
`define REG_MAC_HI      4'd0
`define REG_MAC_LO      4'd1
`define REG_GATEWAY     4'd3
`define REG_IPADDR      4'd4
`define REG_BUF_SIZES   4'd6
`define REG_PORT_CTRL   4'd8
`define REG_XAUI_STATUS 4'd9
`define REG_PHY_CONFIG  4'd10
`define REG_MC_IP       4'd12
`define REG_MC_MASK     4'd13

// reset values
`define DEF_MAC         48'hffff_ffff_ffff
`define DEF_IP          32'hffff_ffff
`define DEF_PORT        16'hffff
`define DEF_GATEWAY     8'd0
`define DEF_ENABLE      1'b0
`define DEF_MC_IP       32'h0000_0000
`define DEF_MC_MASK     32'h0000_0000
`define DEF_RXEQMIX     3'b111
`define DEF_PREEMPH     4'b0100
`define DEF_POSTEMPH    5'b00000
`define DEF_DIFFCTRL    4'b1010

`endif
